// ==== byte_fifo.sv ====
module byte_fifo import rr_arb_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  logic              pop,
    input  logic [data_w-1:0] din,
    output logic [data_w-1:0] head,
    output logic              empty,
    output logic              full,
    output logic              overflow
);

    logic [data_w-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic              do_push;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign empty = (count == '0);
    assign full  = (count == cnt_w'(fifo_depth));

    // a pop in the same cycle frees the slot for the write.
    assign do_push  = push && (!full || pop);
    assign overflow = push && full && !pop;

    assign head = mem[rd_ptr];  // read straight from memory.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage and pointers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({do_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither.
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the scheduler must only pop a queue that holds data.
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> !empty
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n) count <= cnt_w'(fifo_depth)
    );

endmodule

// ==== drop_counter.sv ====
module drop_counter import rr_arb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [num_queues-1:0] overflow,
    output drop_counts_t          drops
);

    logic [num_queues-1:0] at_max;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // saturating counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar g = 0; g < num_queues; g++) begin : g_cnt

        assign at_max[g] = (drops[g] == {drop_w{1'b1}});

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                drops[g] <= '0;
            end else if (overflow[g] && !at_max[g]) begin
                drops[g] <= drops[g] + 1'b1;
            end
        end

        // once saturated it stays there until reset.
        a_no_wrap: assert property (
            @(posedge clk) disable iff (!rst_n) at_max[g] |=> at_max[g]
        );

    end

endmodule

// ==== out_stage.sv ====
module out_stage import rr_arb_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_n,
    input  grant_t                            grant,
    input  logic [num_queues-1:0][data_w-1:0] heads,
    output out_word_t                         out
);

    logic [data_w-1:0] sel_byte;

    assign sel_byte = heads[grant.src];  // head of granted queue.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= grant.pop;
        end
    end

    // src and data hold over idle cycles.
    always_ff @(posedge clk) begin
        if (grant.pop) begin
            out.src  <= grant.src;
            out.data <= sel_byte;
        end
    end

endmodule

// ==== rr_arb_pkg.sv ====
package rr_arb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int num_queues = 4;
    localparam int data_w     = 8;
    localparam int fifo_depth = 8;
    localparam int ptr_w      = 3;
    localparam int cnt_w      = 4;  // holds 0 to fifo_depth.
    localparam int src_w      = 2;
    localparam int drop_w     = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [num_queues-1:0]             strobe;  // one write strobe per queue.
        logic [num_queues-1:0][data_w-1:0] data;    // byte i goes to queue i.
    } wr_bus_t;

    typedef struct packed {
        logic              valid;
        logic [src_w-1:0]  src;   // queue the byte came from.
        logic [data_w-1:0] data;
    } out_word_t;

    typedef logic [num_queues-1:0][drop_w-1:0] drop_counts_t;

    typedef struct packed {
        logic             pop;
        logic [src_w-1:0] src;
    } grant_t;

endpackage

// ==== rr_fifo_arbiter.f ====
rr_arb_pkg.sv
byte_fifo.sv
rr_scheduler.sv
drop_counter.sv
out_stage.sv
rr_fifo_arbiter.sv
tb_rr_fifo_arbiter.sv

// ==== rr_fifo_arbiter.sv ====
module rr_fifo_arbiter import rr_arb_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  wr_bus_t      wr,
    output out_word_t    out,
    output drop_counts_t drops
);

    logic [num_queues-1:0][data_w-1:0] heads;
    logic [num_queues-1:0]             q_empty;
    logic [num_queues-1:0]             q_overflow;
    logic [num_queues-1:0]             q_pop;
    grant_t                            grant;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // producer queues
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar g = 0; g < num_queues; g++) begin : g_q

        assign q_pop[g] = grant.pop && (grant.src == src_w'(g));  // pop decode.

        byte_fifo u_byte_fifo (
            .clk      (clk),
            .rst_n    (rst_n),
            .push     (wr.strobe[g]),
            .pop      (q_pop[g]),
            .din      (wr.data[g]),
            .head     (heads[g]),
            .empty    (q_empty[g]),
            .full     (),
            .overflow (q_overflow[g])
        );

    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scheduler and output
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    rr_scheduler u_rr_scheduler (
        .clk   (clk),
        .rst_n (rst_n),
        .empty (q_empty),
        .grant (grant)
    );

    out_stage u_out_stage (
        .clk   (clk),
        .rst_n (rst_n),
        .grant (grant),
        .heads (heads),
        .out   (out)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drop status
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    drop_counter u_drop_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .overflow (q_overflow),
        .drops    (drops)
    );

endmodule

// ==== rr_scheduler.sv ====
module rr_scheduler import rr_arb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [num_queues-1:0] empty,
    output grant_t                grant
);

    logic [src_w-1:0] last_q;  // last served queue.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // circular search
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // scan last_q+1 upward, last_q itself comes last.
    always_comb begin
        logic [src_w-1:0] cand;
        grant = '0;
        cand  = last_q;
        for (int k = 1; k <= num_queues; k++) begin
            cand = last_q + src_w'(k);  // wraps modulo num_queues.
            if (!grant.pop && !empty[cand]) begin
                grant.pop = 1'b1;
                grant.src = cand;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointer state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= src_w'(num_queues - 1);  // queue 0 first after reset.
        end else if (grant.pop) begin
            last_q <= grant.src;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_grant_not_empty: assert property (
        @(posedge clk) disable iff (!rst_n) grant.pop |-> !empty[grant.src]
    );

    // a served queue is skipped next time while others wait.
    a_rotates: assert property (
        @(posedge clk) disable iff (!rst_n)
        (grant.pop && ($countones(~empty) > 1)) |=> (grant.src != $past(grant.src))
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_rr_fifo_arbiter -f rr_fifo_arbiter.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

result=$(./obj_dir/Vtb_rr_fifo_arbiter)
status=$?
echo "$result"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$result" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// ==== tb_rr_fifo_arbiter.sv ====
module tb_rr_fifo_arbiter import rr_arb_pkg::*; ();

    localparam int max_cycles = 4000;  // tests take about 3100 cycles.

    logic         clk;
    logic         rst_n;
    wr_bus_t      wr;
    out_word_t    dut_out;
    drop_counts_t dut_drops;

    logic [15:0]  lfsr_state;
    int           cycles;
    int           err_out;
    int           err_drops;
    int           err_other;
    string        test_name;

    logic             rot_on;
    logic             have_prev;
    logic [src_w-1:0] prev_src;
    logic             marker_on;
    int               marker_seen;

    // model state.
    logic [data_w-1:0] m_mem [num_queues][fifo_depth];
    int                m_rd  [num_queues];
    int                m_cnt [num_queues];
    int                m_last;
    out_word_t         exp_out;
    drop_counts_t      exp_drops;

    rr_fifo_arbiter u_rr_fifo_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .out   (dut_out),
        .drops (dut_drops)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic rand_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 16'hB400;  // x^16+x^14+x^13+x^11+1.
        end
        return b;
    endfunction

    function automatic logic [data_w-1:0] rand_byte();
        logic [data_w-1:0] r;
        r = '0;
        for (int b = 0; b < data_w; b++) begin
            r = {r[data_w-2:0], rand_bit()};
        end
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic model_busy();
        logic busy;
        busy = 1'b0;
        for (int q = 0; q < num_queues; q++) begin
            if (m_cnt[q] > 0) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    always @(posedge clk) begin : model_step
        logic g_pop;
        int   g_src;
        int   cand;
        int   wpos;
        logic pop_q;
        if (!rst_n) begin
            exp_out   = '0;
            exp_drops = '0;
            m_last    = num_queues - 1;
            for (int q = 0; q < num_queues; q++) begin
                m_rd[q]  = 0;
                m_cnt[q] = 0;
            end
        end else begin
            g_pop = 1'b0;
            g_src = 0;
            for (int k = 1; k <= num_queues; k++) begin
                cand = (m_last + k) % num_queues;
                if (!g_pop && m_cnt[cand] > 0) begin
                    g_pop = 1'b1;
                    g_src = cand;
                end
            end
            exp_out.valid = g_pop;
            if (g_pop) begin
                exp_out.src  = src_w'(g_src);
                exp_out.data = m_mem[g_src][m_rd[g_src]];
                m_last       = g_src;
            end
            for (int q = 0; q < num_queues; q++) begin
                pop_q = g_pop && (g_src == q);
                wpos  = (m_rd[q] + m_cnt[q]) % fifo_depth;
                if (pop_q) begin
                    m_rd[q]  = (m_rd[q] + 1) % fifo_depth;
                    m_cnt[q] = m_cnt[q] - 1;
                end
                if (wr.strobe[q] && m_cnt[q] == fifo_depth) begin
                    if (exp_drops[q] != 8'hff) begin
                        exp_drops[q] = exp_drops[q] + 8'd1;
                    end
                end else if (wr.strobe[q]) begin
                    m_mem[q][wpos] = wr.data[q];
                    m_cnt[q]       = m_cnt[q] + 1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_out(input string name, input out_word_t exp, input out_word_t act);
        if (exp.valid !== act.valid ||
            (exp.valid && (exp.src !== act.src || exp.data !== act.data))) begin
            err_out++;
            $display("mismatch %s out: expected valid %0b src %0d data %02h", name,
                     exp.valid, exp.src, exp.data);
            $display("    actual valid %0b src %0d data %02h", act.valid, act.src, act.data);
        end
    endtask

    task automatic check_drops(input string name, input drop_counts_t exp,
                               input drop_counts_t act);
        if (exp !== act) begin
            err_drops++;
            $display("mismatch %s drops: expected %08h actual %08h", name, exp, act);
        end
    endtask

    always @(negedge clk) begin : monitor
        logic [src_w-1:0] next_src;
        if (rst_n) begin
            check_out(test_name, exp_out, dut_out);
            check_drops(test_name, exp_drops, dut_drops);
            if (rot_on && exp_out.valid) begin
                next_src = prev_src + 1'b1;
                if (have_prev && dut_out.src !== next_src) begin
                    err_out++;
                    $display("mismatch %s rotation: expected src %0d actual %0d",
                             test_name, next_src, dut_out.src);
                end
                prev_src  = exp_out.src;
                have_prev = 1'b1;
            end
            if (marker_on && dut_out.valid && dut_out.data >= 8'he0) begin
                marker_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        wr    <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // each strobe is the and of level random bits.
    task automatic drive_random(input int n, input int level);
        wr_bus_t w;
        logic    s;
        for (int c = 0; c < n; c++) begin
            for (int q = 0; q < num_queues; q++) begin
                s = 1'b1;
                for (int b = 0; b < level; b++) begin
                    s = s & rand_bit();
                end
                w.strobe[q] = s;
                w.data[q]   = rand_byte();
            end
            @(posedge clk);
            wr <= w;
        end
    endtask

    // all queues written every cycle.
    task automatic drive_all(input int n, input logic pattern);
        wr_bus_t w;
        for (int c = 0; c < n; c++) begin
            w.strobe = '1;
            for (int q = 0; q < num_queues; q++) begin
                w.data[q] = pattern ? data_w'(q * 16 + (c % 16)) : rand_byte();
            end
            @(posedge clk);
            wr <= w;
        end
    endtask

    task automatic wait_drain();
        @(posedge clk);
        wr <= '0;
        @(negedge clk);
        while (dut_out.valid || model_busy()) begin
            @(negedge clk);
        end
    endtask

    initial begin
        wr_bus_t      w;
        drop_counts_t snap;
        rst_n       = 1'b0;
        wr          = '0;
        lfsr_state  = 16'd76;
        cycles      = 0;
        err_out     = 0;
        err_drops   = 0;
        err_other   = 0;
        rot_on      = 1'b0;
        have_prev   = 1'b0;
        prev_src    = '0;
        marker_on   = 1'b0;
        marker_seen = 0;
        test_name   = "reset";
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "reset_idle";
        repeat (8) begin
            @(negedge clk);
            check_out(test_name, '0, dut_out);
            check_drops(test_name, '0, dut_drops);
        end

        test_name = "sparse_random";
        drive_random(400, 2);
        wait_drain();

        test_name = "fill_and_drain";
        rot_on    = 1'b1;
        drive_all(16, 1'b0);
        wait_drain();
        rot_on = 1'b0;

        // queues full, only the popped one takes its marker.
        test_name = "same_cycle_write";
        marker_on = 1'b1;
        drive_all(16, 1'b1);
        w.strobe = '1;
        for (int q = 0; q < num_queues; q++) begin
            w.data[q] = data_w'(224 + q);
        end
        for (int i = 0; i < num_queues; i++) begin
            @(posedge clk);
            wr <= w;
            if (i == 0) begin
                @(negedge clk);
                snap = exp_drops;
            end
        end
        @(posedge clk);
        wr <= '0;
        @(negedge clk);
        for (int q = 0; q < num_queues; q++) begin
            snap[q] = snap[q] + 8'd3;
        end
        check_drops(test_name, snap, dut_drops);
        wait_drain();
        if (marker_seen != num_queues) begin
            err_other++;
            $display("mismatch %s markers: expected %0d actual %0d", test_name,
                     num_queues, marker_seen);
        end
        marker_on = 1'b0;

        test_name = "single_burst";
        @(negedge clk);
        snap   = exp_drops;
        w      = '0;
        w.strobe[1] = 1'b1;
        for (int c = 0; c < 40; c++) begin
            w.data[1] = rand_byte();
            @(posedge clk);
            wr <= w;
        end
        wait_drain();
        check_drops(test_name, snap, dut_drops);

        test_name = "overload_saturation";
        drive_all(400, 1'b0);
        wait_drain();
        check_drops(test_name, '1, dut_drops);

        apply_reset();
        test_name = "mixed_random";
        for (int p = 0; p < 2; p++) begin
            drive_random(500, 1);
            drive_random(500, 3);
        end
        wait_drain();

        repeat (2) @(posedge clk);
        $display("errors: out %0d, drops %0d, other %0d", err_out, err_drops, err_other);
        if (err_out + err_drops + err_other == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
